// File: tb.f
+incdir+.
xbar_map_pkg.sv
xbar_data_pkg.sv
slv_arbiter.sv
mstr_port.sv
slv_mem_port.sv
tcm_xbar.sv
tb_tcm_xbar_sva.sv
tb_tcm_xbar.sv

// File: Makefile
# Verilator build and run of the TCM crossbar testbench

TOP = tb_tcm_xbar

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

# the log decides the result
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tb_tcm_xbar.sv
// ==================================================
// TCM crossbar testbench
// random traffic from three masters into memory models,
// checked against a reference of map, arbitration and data
// ==================================================
`include "xbar_cfg.svh"

module tb_tcm_xbar;

  import xbar_data_pkg::*;

  localparam int N_TXN     = 1000;
  localparam int MAX_CYCLE = 4000;  // 4 cycles per transaction with margin

  logic clk_i  = 1'b0;
  logic rstn_i = 1'b0;

  // masters: 0 data, 1 instr, 2 debug
  logic   [2:0] m_req   = '0;
  logic   [2:0] m_we    = '0;
  addr_t  [2:0] m_addr  = '0;
  be_t    [2:0] m_be    = '0;
  tword_t [2:0] m_wdata = '0;
  logic   [2:0] m_gnt, m_rvalid, m_err;
  tword_t [2:0] m_rdata;
  word_t        instr_rdata;

  // memories: 0 IROM, 1 IRAM, 2 DRAM
  logic   [2:0] s_ready = '1;
  logic   [2:0] s_error = '0;
  tword_t [2:0] s_rdata = '0;
  logic   [2:0] s_en, s_we;
  addr_t  [2:0] s_addr;
  be_t    [2:0] s_be;
  tword_t [2:0] s_wdata;
  word_t        irom_wdata;

  tword_t mem_model [logic [33:0]];  // {slave, addr}
  tword_t ref_mem   [addr_t];

  // one response owed per master at most
  logic   [2:0] exp_pend  = '0;
  logic   [2:0] exp_read  = '0;
  logic   [2:0] exp_err   = '0;
  tword_t [2:0] exp_rdata = '0;
  int           rr_last [3] = '{-1, -1, -1};

  integer seed = 22;
  int     cycle = 0;
  int     n_done = 0;
  int     n_gnt_err = 0;
  int     n_port_err = 0;
  int     n_rsp_err = 0;
  logic   drained = 1'b0;
  logic   timed_out = 1'b0;

  assign m_rdata[1] = tword_t'(instr_rdata);
  assign s_wdata[0] = tword_t'(irom_wdata);

  always #5 clk_i = ~clk_i;

  tcm_xbar i_tcm_xbar (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .data_req_i     (m_req[0]),
    .data_gnt_o     (m_gnt[0]),
    .data_addr_i    (m_addr[0]),
    .data_be_i      (m_be[0]),
    .data_wdata_i   (m_wdata[0]),
    .data_we_i      (m_we[0]),
    .data_rdata_o   (m_rdata[0]),
    .data_rvalid_o  (m_rvalid[0]),
    .data_err_o     (m_err[0]),
    .instr_req_i    (m_req[1]),
    .instr_gnt_o    (m_gnt[1]),
    .instr_addr_i   (m_addr[1]),
    .instr_rdata_o  (instr_rdata),
    .instr_rvalid_o (m_rvalid[1]),
    .instr_err_o    (m_err[1]),
    .dbg_req_i      (m_req[2]),
    .dbg_gnt_o      (m_gnt[2]),
    .dbg_addr_i     (m_addr[2]),
    .dbg_be_i       (m_be[2]),
    .dbg_wdata_i    (m_wdata[2]),
    .dbg_we_i       (m_we[2]),
    .dbg_rdata_o    (m_rdata[2]),
    .dbg_rvalid_o   (m_rvalid[2]),
    .dbg_err_o      (m_err[2]),
    .irom_en_o      (s_en[0]),
    .irom_addr_o    (s_addr[0]),
    .irom_be_o      (s_be[0]),
    .irom_we_o      (s_we[0]),
    .irom_wdata_o   (irom_wdata),
    .irom_rdata_i   (s_rdata[0][31:0]),
    .irom_ready_i   (s_ready[0]),
    .irom_error_i   (s_error[0]),
    .iram_en_o      (s_en[1]),
    .iram_addr_o    (s_addr[1]),
    .iram_be_o      (s_be[1]),
    .iram_we_o      (s_we[1]),
    .iram_wdata_o   (s_wdata[1]),
    .iram_rdata_i   (s_rdata[1]),
    .iram_ready_i   (s_ready[1]),
    .iram_error_i   (s_error[1]),
    .dram_en_o      (s_en[2]),
    .dram_addr_o    (s_addr[2]),
    .dram_be_o      (s_be[2]),
    .dram_we_o      (s_we[2]),
    .dram_wdata_o   (s_wdata[2]),
    .dram_rdata_i   (s_rdata[2]),
    .dram_ready_i   (s_ready[2]),
    .dram_error_i   (s_error[2])
  );

  function automatic int region_of(addr_t a);
    if (a >= `XBAR_IROM_START && a < `XBAR_IROM_END) return 0;
    if (a >= `XBAR_IRAM_START && a < `XBAR_IRAM_END) return 1;
    return 2;  // DRAM and unmapped space
  endfunction

  // power-up contents, distinct for every word
  function automatic tword_t fill_word(addr_t a);
    return {^a, a ^ 32'h5EED_C0DE};
  endfunction

  function automatic tword_t merge_bytes(tword_t old, tword_t wd, be_t be);
    tword_t res;
    res = {wd[32], old[31:0]};  // tag follows every write
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  function automatic int arb_pick(logic [2:0] reqs, int s, int last);
    if (s != 0) begin  // IRAM and DRAM rotate
      for (int i = last + 1; i < 3; i++) begin
        if (reqs[i]) return i;
      end
    end
    for (int i = 0; i < 3; i++) begin
      if (reqs[i]) return i;
    end
    return -1;
  endfunction

  task automatic new_request(input int m);
    addr_t base;
    case ($unsigned($random(seed)) % 5)
      0:       base = `XBAR_IROM_START;
      1:       base = `XBAR_IROM_END - 32'h40;  // top of IROM
      2:       base = `XBAR_IRAM_START;
      3:       base = `XBAR_DRAM_START;
      default: base = 32'h200C_0000;            // unmapped gap
    endcase
    m_req[m]   <= 1'b1;
    m_addr[m]  <= base + addr_t'(($unsigned($random(seed)) % 16) * 4);
    m_be[m]    <= (m == 1) ? 4'hF : be_t'($random(seed));
    m_wdata[m] <= (m == 1) ? tword_t'(0) : tword_t'({$random(seed), $random(seed)});
    m_we[m]    <= (m != 1) && (($random(seed) & 1) != 0);
  endtask

  // ==================================================
  // memory models, answer the cycle after a grant
  // ==================================================
  always @(posedge clk_i) begin
    logic [33:0] key;
    tword_t      cur;
    for (int s = 0; s < 3; s++) begin
      if (rstn_i && s_en[s] && s_ready[s]) begin
        key = {2'(s), s_addr[s]};
        cur = mem_model.exists(key) ? mem_model[key] : fill_word(s_addr[s]);
        if (s == 0) cur[32] = 1'b0;  // 32-bit IROM
        s_rdata[s] <= cur;
        s_error[s] <= s_addr[s][2] & s_addr[s][3];
        if (s_we[s]) mem_model[key] = merge_bytes(cur, s_wdata[s], s_be[s]);
      end
    end
  end

  // ==================================================
  // reference model, checks and stimulus
  // ==================================================
  always @(posedge clk_i) begin
    logic [2:0] reqs;
    logic [2:0] exp_gnt;
    logic [2:0] new_pend;
    logic       wd_ok;
    int         win;
    int         s;
    addr_t      a;
    tword_t     cur;
    if (rstn_i) begin
      cycle++;
      exp_gnt  = '0;
      new_pend = '0;

      for (int m = 0; m < 3; m++) begin
        assert (m_rvalid[m] === exp_pend[m]) else begin
          n_rsp_err++;
          $display("MISMATCH at %0t: master %0d rvalid %b, expected %b",
                   $time, m, m_rvalid[m], exp_pend[m]);
        end
        if (exp_pend[m] && m_rvalid[m]) begin
          assert (m_err[m] === exp_err[m]) else begin
            n_rsp_err++;
            $display("MISMATCH at %0t: master %0d err %b, expected %b",
                     $time, m, m_err[m], exp_err[m]);
          end
          assert (!exp_read[m] || m_rdata[m] === exp_rdata[m]) else begin
            n_rsp_err++;
            $display("MISMATCH at %0t: master %0d rdata %h, expected %h",
                     $time, m, m_rdata[m], exp_rdata[m]);
          end
        end
      end

      for (s = 0; s < 3; s++) begin
        reqs = '0;
        for (int m = 0; m < 3; m++) begin
          if (m_req[m] && region_of(m_addr[m]) == s) reqs[m] = 1'b1;
        end
        assert (s_en[s] === (reqs != '0)) else begin
          n_port_err++;
          $display("MISMATCH at %0t: slave %0d en %b with requests %b", $time, s, s_en[s], reqs);
        end
        win = s_ready[s] ? arb_pick(reqs, s, rr_last[s]) : -1;
        if (win >= 0) begin
          exp_gnt[win] = 1'b1;
          rr_last[s]   = win;
        end
      end
      assert (m_gnt === exp_gnt) else begin
        n_gnt_err++;
        $display("MISMATCH at %0t: grants %b, expected %b", $time, m_gnt, exp_gnt);
      end

      for (int m = 0; m < 3; m++) begin
        if (m_gnt[m] && exp_gnt[m]) begin
          a     = m_addr[m];
          s     = region_of(a);
          wd_ok = (s == 0) ? (s_wdata[0][31:0] === m_wdata[m][31:0])
                           : (s_wdata[s] === m_wdata[m]);
          assert (s_addr[s] === a && s_be[s] === m_be[m] && s_we[s] === m_we[m] &&
                  (!m_we[m] || wd_ok)) else begin
            n_port_err++;
            $display("MISMATCH at %0t: master %0d request not seen on slave %0d",
                     $time, m, s);
          end
          cur = ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
          if (s == 0) cur[32] = 1'b0;
          exp_read[m]  = !m_we[m];
          exp_rdata[m] = (m == 1) ? {1'b0, cur[31:0]} : cur;
          exp_err[m]   = a[2] & a[3];
          if (m_we[m]) begin
            cur = merge_bytes(cur, m_wdata[m], m_be[m]);
            if (s == 0) cur[32] = 1'b0;  // tag dropped on the way in
            ref_mem[a] = cur;
          end
          new_pend[m] = 1'b1;
          n_done++;
        end
        // a request is held until granted
        if (!m_req[m] || m_gnt[m]) begin
          if (n_done < N_TXN && ($random(seed) & 3) != 0) begin
            new_request(m);
          end else begin
            m_req[m] <= 1'b0;
          end
        end
      end
      exp_pend = new_pend;

      for (s = 0; s < 3; s++) begin
        s_ready[s] <= ($random(seed) & 3) != 0;
      end

      if (n_done >= N_TXN && m_req == '0 && new_pend == '0) drained = 1'b1;
      if (cycle >= MAX_CYCLE) timed_out = 1'b1;
    end
  end

  initial begin
    repeat (4) @(posedge clk_i);
    rstn_i <= 1'b1;
    wait (drained || timed_out);
    if (timed_out) begin
      $display("timeout: traffic did not drain within %0d cycles", MAX_CYCLE);
    end
    $display("errors: grant %0d, port %0d, response %0d over %0d transactions",
             n_gnt_err, n_port_err, n_rsp_err, n_done);
    if (timed_out || (n_gnt_err + n_port_err + n_rsp_err) != 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

// File: tb_tcm_xbar_sva.sv
// ==================================================
// TCM crossbar assertions
// one grant per slave, rvalid one cycle after each grant
// ==================================================
`include "xbar_cfg.svh"

module tb_tcm_xbar_sva (
  input logic                                      clk_i,
  input logic                                      rstn_i,
  input xbar_map_pkg::mstr_vec_t                   gnt_i,     // {dbg, instr, data}
  input xbar_map_pkg::mstr_vec_t                   rvalid_i,
  input xbar_map_pkg::slv_vec_t [`XBAR_N_MSTR-1:0] sreq_i
);

  import xbar_map_pkg::*;

  for (genvar s = 0; s < `XBAR_N_SLV; s++) begin : g_slv
    mstr_vec_t gnt_here;  // masters granted by this slave

    for (genvar m = 0; m < `XBAR_N_MSTR; m++) begin : g_m
      assign gnt_here[m] = gnt_i[m] & sreq_i[m][s];
    end

    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rstn_i)
      $onehot0(gnt_here))
      else $error("slave %0d granted more than one master", s);

  end

  for (genvar m = 0; m < `XBAR_N_MSTR; m++) begin : g_mstr

    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rstn_i)
      gnt_i[m] |=> rvalid_i[m])
      else $error("master %0d got no rvalid one cycle after a grant", m);

    // one response per grant
    a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rvalid_i[m] |-> $past(gnt_i[m]))
      else $error("master %0d got rvalid without a grant", m);

  end

endmodule

bind tcm_xbar tb_tcm_xbar_sva i_sva (
  .clk_i    (clk_i),
  .rstn_i   (rstn_i),
  .gnt_i    ({dbg_gnt_o, instr_gnt_o, data_gnt_o}),
  .rvalid_i ({dbg_rvalid_o, instr_rvalid_o, data_rvalid_o}),
  .sreq_i   ({dbg_sreq, instr_sreq, data_sreq})
);

// File: tcm_xbar.sv
// ================================================
// TCM crossbar top
// data, instruction and debug masters onto IROM, IRAM, DRAM
// ================================================
`include "xbar_cfg.svh"

module tcm_xbar (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  input  logic                  data_req_i,
  output logic                  data_gnt_o,
  input  xbar_data_pkg::addr_t  data_addr_i,
  input  xbar_data_pkg::be_t    data_be_i,
  input  xbar_data_pkg::tword_t data_wdata_i,
  input  logic                  data_we_i,
  output xbar_data_pkg::tword_t data_rdata_o,
  output logic                  data_rvalid_o,
  output logic                  data_err_o,

  input  logic                  instr_req_i,
  output logic                  instr_gnt_o,
  input  xbar_data_pkg::addr_t  instr_addr_i,
  output xbar_data_pkg::word_t  instr_rdata_o,
  output logic                  instr_rvalid_o,
  output logic                  instr_err_o,

  input  logic                  dbg_req_i,
  output logic                  dbg_gnt_o,
  input  xbar_data_pkg::addr_t  dbg_addr_i,
  input  xbar_data_pkg::be_t    dbg_be_i,
  input  xbar_data_pkg::tword_t dbg_wdata_i,
  input  logic                  dbg_we_i,
  output xbar_data_pkg::tword_t dbg_rdata_o,
  output logic                  dbg_rvalid_o,
  output logic                  dbg_err_o,

  output logic                  irom_en_o,
  output xbar_data_pkg::addr_t  irom_addr_o,
  output xbar_data_pkg::be_t    irom_be_o,
  output logic                  irom_we_o,
  output xbar_data_pkg::word_t  irom_wdata_o,
  input  xbar_data_pkg::word_t  irom_rdata_i,
  input  logic                  irom_ready_i,
  input  logic                  irom_error_i,

  output logic                  iram_en_o,
  output xbar_data_pkg::addr_t  iram_addr_o,
  output xbar_data_pkg::be_t    iram_be_o,
  output logic                  iram_we_o,
  output xbar_data_pkg::tword_t iram_wdata_o,
  input  xbar_data_pkg::tword_t iram_rdata_i,
  input  logic                  iram_ready_i,
  input  logic                  iram_error_i,

  output logic                  dram_en_o,
  output xbar_data_pkg::addr_t  dram_addr_o,
  output xbar_data_pkg::be_t    dram_be_o,
  output logic                  dram_we_o,
  output xbar_data_pkg::tword_t dram_wdata_o,
  input  xbar_data_pkg::tword_t dram_rdata_i,
  input  logic                  dram_ready_i,
  input  logic                  dram_error_i
);

  import xbar_map_pkg::*;
  import xbar_data_pkg::*;

  slv_vec_t  data_sreq, instr_sreq, dbg_sreq;   // per master
  slv_vec_t  data_sgnt, instr_sgnt, dbg_sgnt;
  mstr_vec_t irom_mreq, iram_mreq, dram_mreq;   // per slave
  mstr_vec_t irom_mgnt, iram_mgnt, dram_mgnt;

  addr_t     [`XBAR_N_MSTR-1:0] m2s_addr;
  be_t       [`XBAR_N_MSTR-1:0] m2s_be;
  tword_t    [`XBAR_N_MSTR-1:0] m2s_wdata;
  word_t     [`XBAR_N_MSTR-1:0] m2s_wdata32;  // IROM has no tag
  mstr_vec_t                    m2s_we;

  // response bundle shared by all masters
  tword_t [`XBAR_N_SLV-1:0] s2m_rdata;
  slv_vec_t                 s2m_rvalid;
  slv_vec_t                 s2m_err;
  word_t                    irom_rdata;
  tword_t                   instr_rdata;

  // ================================================
  // request and grant regathering
  // ================================================
  // {dbg, instr, data}
  assign irom_mreq = {dbg_sreq[SLV_IROM], instr_sreq[SLV_IROM], data_sreq[SLV_IROM]};
  assign iram_mreq = {dbg_sreq[SLV_IRAM], instr_sreq[SLV_IRAM], data_sreq[SLV_IRAM]};
  assign dram_mreq = {dbg_sreq[SLV_DRAM], instr_sreq[SLV_DRAM], data_sreq[SLV_DRAM]};

  // {DRAM, IRAM, IROM}
  assign data_sgnt  = {dram_mgnt[MSTR_DATA], iram_mgnt[MSTR_DATA], irom_mgnt[MSTR_DATA]};
  assign instr_sgnt = {dram_mgnt[MSTR_INSTR], iram_mgnt[MSTR_INSTR], irom_mgnt[MSTR_INSTR]};
  assign dbg_sgnt   = {dram_mgnt[MSTR_DBG], iram_mgnt[MSTR_DBG], irom_mgnt[MSTR_DBG]};

  for (genvar i = 0; i < `XBAR_N_MSTR; i++) begin : g_wdata32
    assign m2s_wdata32[i] = word_t'(m2s_wdata[i]);
  end

  assign s2m_rdata[SLV_IROM] = tword_t'(irom_rdata);  // zero tag
  assign instr_rdata_o       = word_t'(instr_rdata);

  // ================================================
  // master ports
  // ================================================
  mstr_port u_data_port (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_i        (data_req_i),
    .gnt_o        (data_gnt_o),
    .addr_i       (data_addr_i),
    .be_i         (data_be_i),
    .wdata_i      (data_wdata_i),
    .we_i         (data_we_i),
    .rdata_o      (data_rdata_o),
    .rvalid_o     (data_rvalid_o),
    .err_o        (data_err_o),
    .slv_req_o    (data_sreq),
    .slv_addr_o   (m2s_addr[MSTR_DATA]),
    .slv_be_o     (m2s_be[MSTR_DATA]),
    .slv_wdata_o  (m2s_wdata[MSTR_DATA]),
    .slv_we_o     (m2s_we[MSTR_DATA]),
    .slv_gnt_i    (data_sgnt),
    .slv_rdata_i  (s2m_rdata),
    .slv_rvalid_i (s2m_rvalid),
    .slv_err_i    (s2m_err)
  );

  // fetch only, full-word reads
  mstr_port u_instr_port (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_i        (instr_req_i),
    .gnt_o        (instr_gnt_o),
    .addr_i       (instr_addr_i),
    .be_i         (be_t'('1)),
    .wdata_i      (tword_t'(0)),
    .we_i         (1'b0),
    .rdata_o      (instr_rdata),
    .rvalid_o     (instr_rvalid_o),
    .err_o        (instr_err_o),
    .slv_req_o    (instr_sreq),
    .slv_addr_o   (m2s_addr[MSTR_INSTR]),
    .slv_be_o     (m2s_be[MSTR_INSTR]),
    .slv_wdata_o  (m2s_wdata[MSTR_INSTR]),
    .slv_we_o     (m2s_we[MSTR_INSTR]),
    .slv_gnt_i    (instr_sgnt),
    .slv_rdata_i  (s2m_rdata),
    .slv_rvalid_i (s2m_rvalid),
    .slv_err_i    (s2m_err)
  );

  mstr_port u_dbg_port (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_i        (dbg_req_i),
    .gnt_o        (dbg_gnt_o),
    .addr_i       (dbg_addr_i),
    .be_i         (dbg_be_i),
    .wdata_i      (dbg_wdata_i),
    .we_i         (dbg_we_i),
    .rdata_o      (dbg_rdata_o),
    .rvalid_o     (dbg_rvalid_o),
    .err_o        (dbg_err_o),
    .slv_req_o    (dbg_sreq),
    .slv_addr_o   (m2s_addr[MSTR_DBG]),
    .slv_be_o     (m2s_be[MSTR_DBG]),
    .slv_wdata_o  (m2s_wdata[MSTR_DBG]),
    .slv_we_o     (m2s_we[MSTR_DBG]),
    .slv_gnt_i    (dbg_sgnt),
    .slv_rdata_i  (s2m_rdata),
    .slv_rvalid_i (s2m_rvalid),
    .slv_err_i    (s2m_err)
  );

  // ================================================
  // slave ports
  // ================================================
  slv_mem_port #(
    .payload_t (word_t),
    .arb_kind  (ARB_FIXED)
  ) u_irom_port (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .mreq_i      (irom_mreq),
    .mgnt_o      (irom_mgnt),
    .maddr_i     (m2s_addr),
    .mbe_i       (m2s_be),
    .mwdata_i    (m2s_wdata32),
    .mwe_i       (m2s_we),
    .rdata_o     (irom_rdata),
    .rvalid_o    (s2m_rvalid[SLV_IROM]),
    .err_o       (s2m_err[SLV_IROM]),
    .mem_en_o    (irom_en_o),
    .mem_we_o    (irom_we_o),
    .mem_addr_o  (irom_addr_o),
    .mem_be_o    (irom_be_o),
    .mem_wdata_o (irom_wdata_o),
    .mem_rdata_i (irom_rdata_i),
    .mem_ready_i (irom_ready_i),
    .mem_error_i (irom_error_i)
  );

  slv_mem_port #(
    .payload_t (tword_t),
    .arb_kind  (ARB_RR)
  ) u_iram_port (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .mreq_i      (iram_mreq),
    .mgnt_o      (iram_mgnt),
    .maddr_i     (m2s_addr),
    .mbe_i       (m2s_be),
    .mwdata_i    (m2s_wdata),
    .mwe_i       (m2s_we),
    .rdata_o     (s2m_rdata[SLV_IRAM]),
    .rvalid_o    (s2m_rvalid[SLV_IRAM]),
    .err_o       (s2m_err[SLV_IRAM]),
    .mem_en_o    (iram_en_o),
    .mem_we_o    (iram_we_o),
    .mem_addr_o  (iram_addr_o),
    .mem_be_o    (iram_be_o),
    .mem_wdata_o (iram_wdata_o),
    .mem_rdata_i (iram_rdata_i),
    .mem_ready_i (iram_ready_i),
    .mem_error_i (iram_error_i)
  );

  slv_mem_port #(
    .payload_t (tword_t),
    .arb_kind  (ARB_RR)
  ) u_dram_port (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .mreq_i      (dram_mreq),
    .mgnt_o      (dram_mgnt),
    .maddr_i     (m2s_addr),
    .mbe_i       (m2s_be),
    .mwdata_i    (m2s_wdata),
    .mwe_i       (m2s_we),
    .rdata_o     (s2m_rdata[SLV_DRAM]),
    .rvalid_o    (s2m_rvalid[SLV_DRAM]),
    .err_o       (s2m_err[SLV_DRAM]),
    .mem_en_o    (dram_en_o),
    .mem_we_o    (dram_we_o),
    .mem_addr_o  (dram_addr_o),
    .mem_be_o    (dram_be_o),
    .mem_wdata_o (dram_wdata_o),
    .mem_rdata_i (dram_rdata_i),
    .mem_ready_i (dram_ready_i),
    .mem_error_i (dram_error_i)
  );

endmodule

// File: slv_mem_port.sv
// ================================================
// TCM crossbar slave port
// arbitrates the masters, drives the memory port
// and returns the response one cycle later
// ================================================
`include "xbar_cfg.svh"

module slv_mem_port #(
  parameter type                     payload_t = xbar_data_pkg::tword_t,
  parameter xbar_map_pkg::arb_kind_e arb_kind  = xbar_map_pkg::ARB_RR
) (
  input  logic                                     clk_i,
  input  logic                                     rstn_i,

  // master side
  input  xbar_map_pkg::mstr_vec_t                  mreq_i,
  output xbar_map_pkg::mstr_vec_t                  mgnt_o,
  input  xbar_data_pkg::addr_t [`XBAR_N_MSTR-1:0]  maddr_i,
  input  xbar_data_pkg::be_t   [`XBAR_N_MSTR-1:0]  mbe_i,
  input  payload_t             [`XBAR_N_MSTR-1:0]  mwdata_i,
  input  xbar_map_pkg::mstr_vec_t                  mwe_i,
  output payload_t                                 rdata_o,
  output logic                                     rvalid_o,
  output logic                                     err_o,

  // memory side
  output logic                                     mem_en_o,
  output logic                                     mem_we_o,
  output xbar_data_pkg::addr_t                     mem_addr_o,
  output xbar_data_pkg::be_t                       mem_be_o,
  output payload_t                                 mem_wdata_o,
  input  payload_t                                 mem_rdata_i,
  input  logic                                     mem_ready_i,
  input  logic                                     mem_error_i
);

  import xbar_map_pkg::*;

  mstr_vec_t sel;       // arbiter choice, before ready
  logic      rvalid_q;

  slv_arbiter #(
    .arb_kind (arb_kind)
  ) u_arbiter (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .req_i    (mreq_i),
    .accept_i (|mgnt_o),
    .gnt_o    (sel)
  );

  assign mem_en_o = |sel;
  assign mgnt_o   = sel & {`XBAR_N_MSTR{mem_ready_i}};

  // sel is one-hot
  always_comb begin
    mem_addr_o  = '0;
    mem_be_o    = '0;
    mem_wdata_o = '0;
    mem_we_o    = 1'b0;
    for (int i = 0; i < `XBAR_N_MSTR; i++) begin
      if (sel[i]) begin
        mem_addr_o  = maddr_i[i];
        mem_be_o    = mbe_i[i];
        mem_wdata_o = mwdata_i[i];
        mem_we_o    = mwe_i[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= |mgnt_o;
    end
  end

  assign rdata_o  = mem_rdata_i;
  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q & mem_error_i;  // memory error only counts with rvalid

endmodule

// File: mstr_port.sv
// ================================================
// TCM crossbar master port
// decodes the address to a slave, holds a slave switch
// until the owed response is back, routes it home
// ================================================
`include "xbar_cfg.svh"

module mstr_port (
  input  logic                                    clk_i,
  input  logic                                    rstn_i,

  input  logic                                    req_i,
  output logic                                    gnt_o,
  input  xbar_data_pkg::addr_t                    addr_i,
  input  xbar_data_pkg::be_t                      be_i,
  input  xbar_data_pkg::tword_t                   wdata_i,
  input  logic                                    we_i,
  output xbar_data_pkg::tword_t                   rdata_o,
  output logic                                    rvalid_o,
  output logic                                    err_o,

  // slave side
  output xbar_map_pkg::slv_vec_t                  slv_req_o,
  output xbar_data_pkg::addr_t                    slv_addr_o,
  output xbar_data_pkg::be_t                      slv_be_o,
  output xbar_data_pkg::tword_t                   slv_wdata_o,
  output logic                                    slv_we_o,
  input  xbar_map_pkg::slv_vec_t                  slv_gnt_i,
  input  xbar_data_pkg::tword_t [`XBAR_N_SLV-1:0] slv_rdata_i,
  input  xbar_map_pkg::slv_vec_t                  slv_rvalid_i,
  input  xbar_map_pkg::slv_vec_t                  slv_err_i
);

  import xbar_map_pkg::*;
  import xbar_data_pkg::*;

  slv_vec_t hit;          // region hits, disjoint
  slv_vec_t slv_dec;
  slv_vec_t pend_q;       // slave that owes us a response
  logic     rvalid_done;

  function automatic logic in_region(addr_t a, addr_t lo, addr_t hi);
    return (a >= lo) && (a < hi);
  endfunction

  // ================================================
  // address decode
  // ================================================
  always_comb begin
    hit           = '0;
    hit[SLV_IROM] = in_region(addr_i, `XBAR_IROM_START, `XBAR_IROM_END);
    hit[SLV_IRAM] = in_region(addr_i, `XBAR_IRAM_START, `XBAR_IRAM_END);
    hit[SLV_DRAM] = in_region(addr_i, `XBAR_DRAM_START, `XBAR_DRAM_END);

    slv_dec = '0;
    if (req_i) begin
      if (|hit) slv_dec = hit;
      else      slv_dec[SLV_DRAM] = 1'b1;  // unmapped goes to DRAM
    end
  end

  assign rvalid_done = |(pend_q & slv_rvalid_i);

  // a different slave has to wait for the pending response
  assign slv_req_o = ((pend_q == '0) || (pend_q == slv_dec) || rvalid_done) ? slv_dec : '0;
  assign gnt_o     = |(slv_gnt_i & slv_req_o);

  assign slv_addr_o  = addr_i;
  assign slv_be_o    = be_i;
  assign slv_wdata_o = wdata_i;
  assign slv_we_o    = we_i;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pend_q <= '0;
    end else if (gnt_o) begin
      pend_q <= slv_req_o;
    end else if (rvalid_done) begin
      pend_q <= '0;
    end
  end

  // ================================================
  // response select
  // ================================================
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < `XBAR_N_SLV; i++) begin
      if (pend_q[i]) rdata_o = slv_rdata_i[i];
    end
  end

  assign rvalid_o = rvalid_done;
  assign err_o    = |(pend_q & slv_rvalid_i & slv_err_i);

endmodule

// File: slv_arbiter.sv
// ================================================
// TCM crossbar slave arbiter
// fixed priority or round-robin among the masters
// ================================================

module slv_arbiter #(
  parameter xbar_map_pkg::arb_kind_e arb_kind = xbar_map_pkg::ARB_FIXED
) (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  xbar_map_pkg::mstr_vec_t req_i,
  input  logic                    accept_i,  // choice taken by the memory
  output xbar_map_pkg::mstr_vec_t gnt_o
);

  import xbar_map_pkg::*;

  mstr_vec_t last_q;   // last accepted master, one-hot
  mstr_vec_t hi_mask;
  mstr_vec_t req_hi;

  // isolate lowest set bit
  function automatic mstr_vec_t lowest(mstr_vec_t v);
    return v & (~v + mstr_vec_t'(1));
  endfunction

  // masters strictly above last_q, empty after reset
  assign hi_mask = (arb_kind == ARB_RR) ? ~(last_q | (last_q - mstr_vec_t'(1))) : '0;
  assign req_hi  = req_i & hi_mask;

  // wrap to the lowest requester when nobody above asks
  assign gnt_o = (|req_hi) ? lowest(req_hi) : lowest(req_i);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      last_q <= '0;
    end else if (accept_i) begin
      last_q <= gnt_o;
    end
  end

endmodule

// File: xbar_data_pkg.sv
// ================================================
// TCM crossbar payload types
// address, byte enable, plain and tagged words
// ================================================
`include "xbar_cfg.svh"

package xbar_data_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [3:0]  be_t;

  typedef logic [31:0] word_t;

  // capability tag in the top bit
  typedef logic [`XBAR_TAG_BIT:0] tword_t;

endpackage

// File: xbar_map_pkg.sv
// ================================================
// TCM crossbar address map types
// slave and master vectors, arbitration kinds
// ================================================
`include "xbar_cfg.svh"

package xbar_map_pkg;

  localparam int SLV_IDX_W = $clog2(`XBAR_N_SLV);

  typedef logic [SLV_IDX_W-1:0]    slv_idx_t;
  typedef logic [`XBAR_N_SLV-1:0]  slv_vec_t;   // one-hot, one bit per slave
  typedef logic [`XBAR_N_MSTR-1:0] mstr_vec_t;  // bit 0 has top priority

  // slave positions in slv_vec_t
  localparam slv_idx_t SLV_IROM = slv_idx_t'(0);
  localparam slv_idx_t SLV_IRAM = slv_idx_t'(1);
  localparam slv_idx_t SLV_DRAM = slv_idx_t'(2);

  // master positions in mstr_vec_t
  localparam int MSTR_DATA  = 0;
  localparam int MSTR_INSTR = 1;
  localparam int MSTR_DBG   = 2;

  typedef enum logic {
    ARB_FIXED = 1'b0,  // lowest index wins
    ARB_RR    = 1'b1   // round-robin after last accepted
  } arb_kind_e;

endpackage

// File: xbar_cfg.svh
// ================================================
// TCM crossbar configuration
// port counts, region map and capability tag position
// ================================================
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

`define XBAR_N_MSTR 3
`define XBAR_N_SLV  3

// ================================================
// address map, half-open [start, end)
// ================================================
`define XBAR_IROM_START 32'h2000_0000
`define XBAR_IROM_END   32'h2004_0000

`define XBAR_IRAM_START 32'h2004_0000
`define XBAR_IRAM_END   32'h200C_0000

`define XBAR_DRAM_START 32'h200F_0000
`define XBAR_DRAM_END   32'h2010_0000

// tag rides above the 32-bit word
`define XBAR_TAG_BIT 32

`endif
